//--- src/fifo_defs.svh
// sizes, version and threshold defaults of the SRAM FIFO
// included by the datapath package and by every RTL block that needs a width

`ifndef FIFO_DEFS_SVH
`define FIFO_DEFS_SVH

`define SRAM_DEPTH   256    // halfword locations, small for simulation
`define SRAM_AW      20
`define SRAM_DW      16
`define IN_DW        32

`define BUF_DEPTH    4      // on-chip word buffer entries
`define FIFO_VERSION 1

// thresholds in 1/256 of the SRAM depth
`define AF_DEFAULT   242
`define AE_DEFAULT   12

`endif

//--- src/fifo_pkg.sv
// datapath types shared by writer, reader, arbiter and register block
`default_nettype none

`include "fifo_defs.svh"

package fifo_pkg;

    typedef struct packed {
        logic                valid;
        logic [`SRAM_DW-1:0] data;
    } sram_wr_req_t;

    // async SRAM pins, data bus split into out and in
    typedef struct packed {
        logic [`SRAM_AW-1:0] addr;
        logic [`SRAM_DW-1:0] dout;
        logic                oe;      // drive from SRAM, high active
        logic                we_n;
        logic                ce_n;
        logic                bhe_n;
        logic                ble_n;
    } sram_pins_t;

    typedef enum logic [1:0] {
        READ_IDLE,
        READ_FETCH,
        READ_HOLD
    } rd_state_t;

    typedef struct packed {
        logic                empty;
        logic                full;
        logic [`SRAM_AW:0]   level;   // halfwords stored in SRAM
    } fifo_status_t;

endpackage

`default_nettype wire

//--- src/axil_pkg.sv
// AXI4-Lite channel bundles and register map of the FIFO control block
`default_nettype none

package axil_pkg;

    typedef struct packed {
        logic       valid;
        logic [4:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] resp;
    } axil_b_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    typedef enum logic [4:0] {
        REG_CTRL  = 5'h00,   // write: soft clear, read: version
        REG_AF    = 5'h04,
        REG_AE    = 5'h08,
        REG_SIZE  = 5'h0C,
        REG_RDERR = 5'h10
    } reg_addr_t;

endpackage

`default_nettype wire

//--- src/word_buffer.sv
// small ring buffer for input words, absorbs bursts while the SRAM port is busy
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module word_buffer (
    input  wire logic              BUS_CLK,
    input  wire logic              RST,
    input  wire logic              clear,
    input  wire logic              wr_en,
    input  wire logic [`IN_DW-1:0] wr_data,
    input  wire logic              rd_en,
    output logic      [`IN_DW-1:0] rd_data,
    output logic                   full,
    output logic                   empty
);

    localparam int PW = $clog2(`BUF_DEPTH);

    logic [`IN_DW-1:0] mem [`BUF_DEPTH];
    logic [PW-1:0]     wr_ptr;
    logic [PW-1:0]     rd_ptr;
    logic [PW:0]       count;
    logic [PW:0]       count_next;
    logic              do_wr;
    logic              do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;
    assign count_next = count + {{PW{1'b0}}, do_wr} - {{PW{1'b0}}, do_rd};
    assign rd_data = mem[rd_ptr];   // head word, valid while not empty

    // flags are registered, full held high through reset
    always_ff @(posedge BUS_CLK) begin
        if (RST || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b1;
            empty  <= 1'b1;
        end else begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count_next;
            full  <= (count_next == `BUF_DEPTH);
            empty <= (count_next == 0);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (do_wr)
            mem[wr_ptr] <= wr_data;
    end

endmodule

`default_nettype wire

//--- src/sram_writer.sv
// turns buffered 32-bit words into two halfword write requests, low half first
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module sram_writer (
    input  wire logic                BUS_CLK,
    input  wire logic                RST,
    input  wire logic                clear,
    input  wire logic [`IN_DW-1:0]   buf_data,
    input  wire logic                buf_empty,
    output logic                     buf_pop,
    output fifo_pkg::sram_wr_req_t   wr_req,
    input  wire logic                wr_grant
);

    logic hi_q;   // high half is next

    always_comb begin
        wr_req.valid = !buf_empty;
        wr_req.data  = hi_q ? buf_data[`IN_DW-1:`SRAM_DW] : buf_data[`SRAM_DW-1:0];
    end

    // word leaves the buffer together with its upper half
    assign buf_pop = wr_grant && hi_q;

    always_ff @(posedge BUS_CLK) begin
        if (RST || clear)
            hi_q <= 1'b0;
        else if (wr_grant)
            hi_q <= !hi_q;
    end

endmodule

`default_nettype wire

//--- src/sram_reader.sv
// fetches one halfword from SRAM and hands it out as two bytes, low byte first
// also counts host reads that find the FIFO empty
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module sram_reader (
    input  wire logic                BUS_CLK,
    input  wire logic                RST,
    input  wire logic                clear,
    output logic                     rd_req,
    input  wire logic                rd_grant,
    input  wire logic [`SRAM_DW-1:0] rd_data,
    input  wire logic                sram_empty,
    output logic      [7:0]          out_data,
    output logic                     out_valid,
    input  wire logic                out_ready,
    output logic      [7:0]          rd_err_count
);

    fifo_pkg::rd_state_t state;
    logic [`SRAM_DW-1:0] hold_q;
    logic                hi_sel;   // high byte on the output
    logic [7:0]          err_q;
    logic                take;

    assign rd_req    = (state == fifo_pkg::READ_FETCH);
    assign out_valid = (state == fifo_pkg::READ_HOLD);
    assign out_data  = hi_sel ? hold_q[15:8] : hold_q[7:0];
    assign take      = out_valid && out_ready;
    assign rd_err_count = err_q;

    always_ff @(posedge BUS_CLK) begin
        if (RST || clear) begin
            state  <= fifo_pkg::READ_IDLE;
            hi_sel <= 1'b0;
        end else begin
            case (state)
                fifo_pkg::READ_IDLE:
                    if (!sram_empty)
                        state <= fifo_pkg::READ_FETCH;
                fifo_pkg::READ_FETCH:
                    if (rd_grant) begin
                        state  <= fifo_pkg::READ_HOLD;
                        hi_sel <= 1'b0;
                    end
                fifo_pkg::READ_HOLD:
                    if (take) begin
                        hi_sel <= !hi_sel;
                        if (hi_sel)   // both bytes gone, fetch the next one
                            state <= sram_empty ? fifo_pkg::READ_IDLE : fifo_pkg::READ_FETCH;
                    end
                default: state <= fifo_pkg::READ_IDLE;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (rd_grant)
            hold_q <= rd_data;   // SRAM data valid at end of grant cycle
    end

    // saturating empty-read counter
    always_ff @(posedge BUS_CLK) begin
        if (RST || clear)
            err_q <= '0;
        else if (out_ready && !out_valid && sram_empty && err_q != 8'hff)
            err_q <= err_q + 1'b1;
    end

endmodule

`default_nettype wire

//--- src/sram_arbiter.sv
// owns the single SRAM port: read-first arbitration, ring pointers and fill level
// pins follow the grant combinationally, the SRAM latches a write at the rising edge
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module sram_arbiter (
    input  wire logic                 BUS_CLK,
    input  wire logic                 RST,
    input  wire logic                 clear,
    input  fifo_pkg::sram_wr_req_t    wr_req,
    output logic                      wr_grant,
    input  wire logic                 rd_req,
    output logic                      rd_grant,
    output logic      [`SRAM_DW-1:0]  rd_data,
    output fifo_pkg::sram_pins_t      sram,
    input  wire logic [`SRAM_DW-1:0]  sram_din,
    output fifo_pkg::fifo_status_t    status
);

    localparam int AW = `SRAM_AW;
    localparam logic [AW-1:0] LAST = AW'(`SRAM_DEPTH - 1);

    logic [AW-1:0] rd_ptr;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr_nx;
    logic [AW-1:0] wr_ptr_nx;
    logic [AW:0]   level;
    logic          empty;
    logic          full;

    assign rd_ptr_nx = (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
    assign wr_ptr_nx = (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;

    // one slot stays free to tell full from empty
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr_nx == rd_ptr);

    assign rd_grant = rd_req && !empty;                   // reads win
    assign wr_grant = wr_req.valid && !rd_grant && !full;
    assign rd_data  = sram_din;

    always_comb begin
        sram.addr  = rd_grant ? rd_ptr : wr_ptr;
        sram.dout  = wr_req.data;
        sram.oe    = rd_grant;
        sram.we_n  = !wr_grant;
        sram.ce_n  = 1'b0;   // chip always selected
        sram.bhe_n = 1'b0;
        sram.ble_n = 1'b0;
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST || clear) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            level  <= '0;
        end else begin
            if (rd_grant)
                rd_ptr <= rd_ptr_nx;
            if (wr_grant)
                wr_ptr <= wr_ptr_nx;
            if (wr_grant)
                level <= level + 1'b1;
            else if (rd_grant)
                level <= level - 1'b1;   // grants never coincide
        end
    end

    always_comb begin
        status.empty = empty;
        status.full  = full;
        status.level = level;
    end

endmodule

`default_nettype wire

//--- src/fifo_regs.sv
// AXI4-Lite control block: soft clear, thresholds, fill level, read errors
// near_full follows the level with hysteresis between the AF and AE limits
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module fifo_regs (
    input  wire logic               BUS_CLK,
    input  wire logic               RST,
    input  axil_pkg::axil_aw_t      aw,
    input  axil_pkg::axil_w_t       w,
    output logic                    aw_w_ready,
    output axil_pkg::axil_b_t       b,
    input  wire logic               b_ready,
    input  axil_pkg::axil_ar_t      ar,
    output logic                    ar_ready,
    output axil_pkg::axil_r_t       r,
    input  wire logic               r_ready,
    input  fifo_pkg::fifo_status_t  status,
    input  wire logic [7:0]         rd_err_count,
    output logic                    soft_clear,
    output logic                    near_full
);

    logic [7:0]  af_q;
    logic [7:0]  ae_q;
    logic        b_valid_q;
    logic        r_valid_q;
    logic [31:0] r_data_q;
    logic [31:0] rd_mux;
    logic        wr_fire;
    logic        rd_fire;
    logic [31:0] level_w;
    logic [31:0] af_lim;
    logic [31:0] ae_lim;

    assign wr_fire  = aw_w_ready && aw.valid && w.valid;
    assign ar_ready = !r_valid_q;
    assign rd_fire  = ar.valid && ar_ready;

    assign b = '{valid: b_valid_q, resp: 2'b00};
    assign r = '{valid: r_valid_q, data: r_data_q, resp: 2'b00};

    // AXI handshake and soft clear pulse
    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            aw_w_ready <= 1'b0;
            b_valid_q  <= 1'b0;
            r_valid_q  <= 1'b0;
            soft_clear <= 1'b0;
        end else begin
            aw_w_ready <= aw.valid && w.valid && !aw_w_ready && !b_valid_q;   // one-cycle pulse
            if (wr_fire)
                b_valid_q <= 1'b1;
            else if (b_ready)
                b_valid_q <= 1'b0;
            if (rd_fire)
                r_valid_q <= 1'b1;
            else if (r_ready)
                r_valid_q <= 1'b0;
            soft_clear <= wr_fire && (axil_pkg::reg_addr_t'(aw.addr) == axil_pkg::REG_CTRL);
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_clear) begin
            af_q <= 8'(`AF_DEFAULT);
            ae_q <= 8'(`AE_DEFAULT);
        end else if (wr_fire && w.strb[0]) begin
            case (axil_pkg::reg_addr_t'(aw.addr))
                axil_pkg::REG_AF: af_q <= w.data[7:0];
                axil_pkg::REG_AE: ae_q <= w.data[7:0];
                default: ;
            endcase
        end
    end

    always_comb begin
        case (axil_pkg::reg_addr_t'(ar.addr))
            axil_pkg::REG_CTRL:  rd_mux = 32'(`FIFO_VERSION);
            axil_pkg::REG_AF:    rd_mux = {24'd0, af_q};
            axil_pkg::REG_AE:    rd_mux = {24'd0, ae_q};
            axil_pkg::REG_SIZE:  rd_mux = 32'({status.level, 1'b0});   // bytes
            axil_pkg::REG_RDERR: rd_mux = {24'd0, rd_err_count};
            default:             rd_mux = '0;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (rd_fire)
            r_data_q <= rd_mux;
    end

    assign level_w = 32'(status.level);
    assign af_lim  = ((32'(af_q) + 32'd1) * `SRAM_DEPTH) >> 8;
    assign ae_lim  = ((32'(ae_q) + 32'd1) * `SRAM_DEPTH) >> 8;

    always_ff @(posedge BUS_CLK) begin
        if (RST || soft_clear)
            near_full <= 1'b0;
        else if (level_w >= af_lim || af_q == 8'd0)
            near_full <= 1'b1;
        else if ((level_w <= ae_lim && ae_q != 8'd0) || level_w == 0)
            near_full <= 1'b0;   // between limits the flag holds
    end

endmodule

`default_nettype wire

//--- src/sram_fifo_top.sv
// SRAM-backed FIFO: 32-bit word stream in, byte stream out, AXI4-Lite control
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module sram_fifo_top (
    input  wire logic                BUS_CLK,
    input  wire logic                RST,
    input  wire logic [`IN_DW-1:0]   in_data,
    input  wire logic                in_valid,
    output logic                     in_ready,
    output logic      [7:0]          out_data,
    output logic                     out_valid,
    input  wire logic                out_ready,
    input  axil_pkg::axil_aw_t       aw,
    input  axil_pkg::axil_w_t        w,
    output logic                     aw_w_ready,
    output axil_pkg::axil_b_t        b,
    input  wire logic                b_ready,
    input  axil_pkg::axil_ar_t       ar,
    output logic                     ar_ready,
    output axil_pkg::axil_r_t        r,
    input  wire logic                r_ready,
    output fifo_pkg::sram_pins_t     sram,
    input  wire logic [`SRAM_DW-1:0] sram_din,
    output logic                     fifo_not_empty,
    output logic                     fifo_full,
    output logic                     near_full,
    output logic                     read_error
);

    logic                   soft_clear;
    logic [`IN_DW-1:0]      buf_data;
    logic                   buf_full;
    logic                   buf_empty;
    logic                   buf_pop;
    fifo_pkg::sram_wr_req_t wr_req;
    logic                   wr_grant;
    logic                   rd_req;
    logic                   rd_grant;
    logic [`SRAM_DW-1:0]    rd_data;
    fifo_pkg::fifo_status_t status;
    logic [7:0]             rd_err_count;

    assign in_ready       = !buf_full;
    assign fifo_not_empty = !status.empty;
    assign fifo_full      = status.full;
    assign read_error     = |rd_err_count;

    fifo_regs i_regs (
        .BUS_CLK, .RST, .aw, .w, .aw_w_ready, .b, .b_ready, .ar, .ar_ready, .r, .r_ready,
        .status, .rd_err_count, .soft_clear, .near_full
    );

    word_buffer i_buf (
        .BUS_CLK, .RST, .clear(soft_clear), .wr_en(in_valid), .wr_data(in_data),
        .rd_en(buf_pop), .rd_data(buf_data), .full(buf_full), .empty(buf_empty)
    );

    sram_writer i_writer (
        .BUS_CLK, .RST, .clear(soft_clear), .buf_data, .buf_empty, .buf_pop,
        .wr_req, .wr_grant
    );

    sram_reader i_reader (
        .BUS_CLK, .RST, .clear(soft_clear), .rd_req, .rd_grant, .rd_data,
        .sram_empty(status.empty), .out_data, .out_valid, .out_ready, .rd_err_count
    );

    sram_arbiter i_arb (
        .BUS_CLK, .RST, .clear(soft_clear), .wr_req, .wr_grant, .rd_req, .rd_grant,
        .rd_data, .sram, .sram_din, .status
    );

endmodule

`default_nettype wire

//--- test/sram_model.sv
// asynchronous SRAM stand-in for the FIFO testbench
// write latched at the rising edge, read data follows the address
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module sram_model (
    input  wire logic                 BUS_CLK,
    input  fifo_pkg::sram_pins_t      sram,
    output logic      [`SRAM_DW-1:0]  dout
);

    logic [`SRAM_DW-1:0] mem [`SRAM_DEPTH];
    int                  idx;

    assign idx  = int'(sram.addr % `SRAM_DEPTH);
    assign dout = (sram.oe && !sram.ce_n) ? mem[idx] : '0;

    // fill pattern mixes every address bit
    initial begin
        for (int i = 0; i < `SRAM_DEPTH; i++)
            mem[i] = 16'(i * 40503) ^ 16'h5a5a;
    end

    always @(posedge BUS_CLK) begin
        if (!sram.we_n && !sram.ce_n)
            mem[idx] <= sram.dout;
    end

endmodule

`default_nettype wire

//--- test/tb_sram_fifo.sv
// testbench for the SRAM FIFO: random streaming, full, fill level, near_full, errors
// inputs change on the falling edge, transfers are booked just after it
`timescale 1ns/1ps
`default_nettype none

`include "fifo_defs.svh"

module tb_sram_fifo;

    // words sent over all tests
    localparam int WORD_BUDGET = 300 + `SRAM_DEPTH / 2 + `BUF_DEPTH + 3 * 32 + 6 * 23 + 5;
    localparam int LIMIT = 40 * WORD_BUDGET + 2000;

    logic BUS_CLK;
    logic RST;
    logic [31:0] in_data;
    logic in_valid;
    logic in_ready;
    logic [7:0] out_data;
    logic out_valid;
    logic out_ready;
    axil_pkg::axil_aw_t aw;
    axil_pkg::axil_w_t w;
    logic aw_w_ready;
    axil_pkg::axil_b_t b;
    logic b_ready;
    axil_pkg::axil_ar_t ar;
    logic ar_ready;
    axil_pkg::axil_r_t r;
    logic r_ready;
    fifo_pkg::sram_pins_t sram;
    logic [15:0] sram_din;
    logic fifo_not_empty;
    logic fifo_full;
    logic near_full;
    logic read_error;

    logic [31:0] lfsr = 32'h4390_8c94;
    logic [7:0] model_q [$];
    int cycles = 0;
    int accepted = 0;
    int popped = 0;
    logic last_in_ready;
    logic last_awr;
    logic last_arr;
    logic last_bv;
    logic last_rv;
    logic [31:0] last_rdata;

    sram_fifo_top i_dut (.*);
    sram_model i_sram (.BUS_CLK, .sram, .dout(sram_din));

    initial begin
        BUS_CLK = 1'b0;
        forever #4 BUS_CLK = ~BUS_CLK;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32,22,2,1
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp);
            $display("Something failed");
            $fatal(1, "mismatch");
        end
    endtask

    // book this cycle's transfers, then move to the next falling edge
    task automatic step();
        logic [7:0] exp;
        #1;
        if (in_valid && in_ready) begin
            for (int i = 0; i < 4; i++)
                model_q.push_back(in_data[8*i +: 8]);   // low byte first
            accepted++;
        end
        if (out_valid && out_ready) begin
            if (model_q.size() == 0) begin
                $display("an output byte came out although no byte was expected");
                $display("Something failed");
                $fatal(1, "unexpected byte");
            end
            exp = model_q.pop_front();
            check("out_data", 32'(out_data), 32'(exp));
            popped++;
        end
        last_in_ready = in_ready;
        last_awr = aw_w_ready;
        last_arr = ar_ready;
        last_bv = b.valid;
        last_rv = r.valid;
        last_rdata = r.data;
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout, the run went past %0d cycles", LIMIT);
            $display("Something failed");
            $fatal(1, "timeout");
        end
        @(negedge BUS_CLK);
    endtask

    task automatic reg_write(input logic [4:0] addr, input logic [31:0] data);
        aw = '{valid: 1'b1, addr: addr};
        w = '{valid: 1'b1, data: data, strb: 4'hf};
        do step(); while (!last_awr);
        aw.valid = 1'b0;
        w.valid = 1'b0;
        do step(); while (!last_bv);
    endtask

    task automatic reg_read(input logic [4:0] addr, output logic [31:0] data);
        ar = '{valid: 1'b1, addr: addr};
        do step(); while (!last_arr);
        ar.valid = 1'b0;
        do step(); while (!last_rv);
        data = last_rdata;
    endtask

    task automatic send_words(input int k);
        int target;
        int prev;
        target = accepted + k;
        in_data = rand_bits(32);
        while (accepted < target) begin
            in_valid = 1'b1;
            prev = accepted;
            step();
            if (accepted != prev)
                in_data = rand_bits(32);
        end
        in_valid = 1'b0;
    endtask

    task automatic take_bytes(input int n);
        int target;
        target = popped + n;
        while (popped < target) begin
            out_ready = 1'b1;
            step();
        end
        out_ready = 1'b0;
    endtask

    task automatic drain();
        in_valid = 1'b0;
        take_bytes(model_q.size());
        repeat (20) step();
        check("fifo_not_empty", 32'(fifo_not_empty), 32'd0);
    endtask

    function automatic logic nf_rule(input logic nf, input int lvl, input int af, input int ae);
        if (lvl >= ((af + 1) * `SRAM_DEPTH) / 256 || af == 0)
            return 1'b1;
        if ((lvl <= ((ae + 1) * `SRAM_DEPTH) / 256 && ae != 0) || lvl == 0)
            return 1'b0;
        return nf;
    endfunction

    initial begin
        logic [31:0] rd;
        int prev;
        int low_run;
        int k;
        int stored;
        int af;
        int ae;
        int n;
        logic nf;
        RST = 1'b1;
        in_data = '0;
        in_valid = 1'b0;
        out_ready = 1'b0;
        aw = '0;
        w = '0;
        ar = '0;
        b_ready = 1'b1;
        r_ready = 1'b1;
        repeat (4) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        RST = 1'b0;

        // outputs idle right after reset
        check("in_ready", 32'(in_ready), 32'd0);
        check("out_valid", 32'(out_valid), 32'd0);
        check("b.valid", 32'(b.valid), 32'd0);
        check("r.valid", 32'(r.valid), 32'd0);
        check("near_full", 32'(near_full), 32'd0);
        check("sram.we_n", 32'(sram.we_n), 32'd1);
        check("sram.oe", 32'(sram.oe), 32'd0);
        check("fifo_not_empty", 32'(fifo_not_empty), 32'd0);
        repeat (3) step();
        check("in_ready", 32'(in_ready), 32'd1);

        // random streaming
        in_data = rand_bits(32);
        while (accepted < 300) begin
            in_valid = 1'(rand_bits(1));
            out_ready = 1'(rand_bits(1));
            prev = accepted;
            step();
            if (accepted != prev)
                in_data = rand_bits(32);
        end
        drain();

        // back-pressure until full
        prev = accepted;
        low_run = 0;
        in_data = rand_bits(32);
        while (low_run < 20) begin
            in_valid = 1'b1;
            k = accepted;
            step();
            if (accepted != k)
                in_data = rand_bits(32);
            low_run = last_in_ready ? 0 : low_run + 1;
        end
        in_valid = 1'b0;
        check("fifo_full", 32'(fifo_full), 32'd1);
        check("accepted words", 32'(accepted - prev), 32'(`SRAM_DEPTH / 2 + `BUF_DEPTH));
        drain();

        // fill level in bytes
        reg_read(5'h0C, rd);
        check("REG_SIZE", rd, 32'd0);
        repeat (3) begin
            k = 1 + int'(rand_bits(5));
            send_words(k);
            repeat (10) step();
            reg_read(5'h0C, rd);
            check("REG_SIZE", rd, 32'(4 * k - 2));
            check("fifo_not_empty", 32'(fifo_not_empty), 32'd1);
            drain();
        end

        // near_full hysteresis
        af = int'(rand_bits(8));
        ae = int'(rand_bits(8));
        reg_write(5'h04, 32'(af));
        reg_write(5'h08, 32'(ae));
        reg_read(5'h04, rd);
        check("REG_AF", rd, 32'(af));
        reg_read(5'h08, rd);
        check("REG_AE", rd, 32'(ae));
        nf = nf_rule(1'b0, 0, af, ae);
        check("near_full", 32'(near_full), 32'(nf));
        stored = 0;
        repeat (6) begin
            k = 1 + int'(rand_bits(4)) + int'(rand_bits(3));
            if (stored + k > `SRAM_DEPTH / 2)
                k = `SRAM_DEPTH / 2 - stored;   // stay within SRAM plus reader
            send_words(k);
            stored += k;
            repeat (20) step();
            nf = nf_rule(nf, 2 * stored - 1, af, ae);
            check("near_full", 32'(near_full), 32'(nf));
        end
        while (stored > 0) begin
            k = 1 + int'(rand_bits(4));
            if (k > stored)
                k = stored;
            take_bytes(4 * k);
            stored -= k;
            repeat (20) step();
            nf = nf_rule(nf, stored > 0 ? 2 * stored - 1 : 0, af, ae);
            check("near_full", 32'(near_full), 32'(nf));
        end

        // read errors on an empty FIFO
        reg_write(5'h00, 32'd1);
        n = 1 + int'(rand_bits(9)) % 300;
        out_ready = 1'b1;
        repeat (n) step();
        out_ready = 1'b0;
        repeat (3) step();
        reg_read(5'h10, rd);
        check("REG_RDERR", rd, 32'(n > 255 ? 255 : n));
        check("read_error", 32'(read_error), 32'd1);

        // soft reset clears level, errors and thresholds
        reg_write(5'h04, 32'd7);
        reg_write(5'h08, 32'd3);
        send_words(5);
        repeat (10) step();
        check("near_full", 32'(near_full), 32'(nf_rule(1'b0, 2 * 5 - 1, 7, 3)));
        reg_write(5'h00, 32'd0);
        model_q.delete();
        repeat (3) step();
        check("near_full", 32'(near_full), 32'd0);
        reg_read(5'h0C, rd);
        check("REG_SIZE", rd, 32'd0);
        reg_read(5'h10, rd);
        check("REG_RDERR", rd, 32'd0);
        reg_read(5'h04, rd);
        check("REG_AF", rd, 32'(`AF_DEFAULT));
        reg_read(5'h08, rd);
        check("REG_AE", rd, 32'(`AE_DEFAULT));
        reg_read(5'h00, rd);
        check("REG_CTRL", rd, 32'(`FIFO_VERSION));

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+src
src/fifo_pkg.sv
src/axil_pkg.sv
src/word_buffer.sv
src/sram_writer.sv
src/sram_reader.sv
src/sram_arbiter.sv
src/fifo_regs.sv
src/sram_fifo_top.sv
test/sram_model.sv
test/tb_sram_fifo.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_sram_fifo
SEED      ?= 0
BUILD     ?= obj_dir
FILELIST  ?= sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD)
